// File: compile.f
+incdir+sim
hw/cpu_pkg.sv
hw/dp_ctrl_if.sv
hw/instr_if.sv
hw/instr_decoder.sv
hw/control_fsm.sv
hw/datapath.sv
hw/pc_unit.sv
hw/cpu.sv
sim/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - hw/cpu_pkg.sv
  - hw/dp_ctrl_if.sv
  - hw/instr_if.sv
  - hw/instr_decoder.sv
  - hw/control_fsm.sv
  - hw/datapath.sv
  - hw/pc_unit.sv
  - hw/cpu.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_cpu.sv

// File: sim/tb_program.svh
// word layout opcode[15:13] op[12:11] rn[10:8] rd[7:5] shift[4:3] rm[2:0]
// imm8 sits in [7:0] for mov and branches, imm5 in [4:0] for ldr and str
localparam int    prog_len    = 35;
localparam addr_t poison_addr = 9'h1ff;  // r5 = -1, only skipped stores use it
localparam addr_t ldr_addr    = 9'h065;  // r7 + 5

localparam word_t program_image [prog_len] = '{
  16'hd760, 16'hd100, 16'hd200,             // mov r7,#96  mov r1,#rnd  mov r2,#rnd
  16'hc061, 16'hc089, 16'hc0b2, 16'hc0da,   // mov r3..r6 with none, lsl, lsr, asr
  16'ha314, 16'hb566, 16'hb88e,             // add r0,r3,r4 lsr  and r3,r5,r6  mvn r4,r6 lsl
  16'h8700, 16'h8761, 16'h8782,             // str r0 r3 r4 at r7+0..2
  16'h6745, 16'h875d,                       // ldr r2,[r7,#5]  str r2,[r7,#-3]
  16'hd5ff, 16'haf07,                       // mov r5,#-1  cmp r7,r7 gives z
  16'h2201, 16'h2101, 16'h8500, 16'h2401, 16'h8500,  // bne falls, beq and ble jump
  16'haa07, 16'h2101, 16'h2301, 16'h8500,            // cmp r2,r7 gives n, blt jumps
  16'haf02, 16'h2301, 16'h2401, 16'h2201, 16'h8500,  // cmp r7,r2, blt ble fall, bne jumps
  16'h2001, 16'h8500, 16'ha903, 16'he000             // b, random cmp r1,r3, halt
};

task automatic load_program();
  for (int i = 0; i < mem_words; i++) begin
    mem[i] = (i < prog_len) ? program_image[i] : {7'h2d, addr_t'(i)};  // opcode 010 halts
  end
  mem[ldr_addr] = 16'ha5c3;  // negative so the second cmp sets n
endtask

// random imm8 operands of the first two mov immediates
task automatic patch_operands();
  lcg_state   = lcg_next(lcg_state);
  mem[1][7:0] = lcg_state[23:16];
  lcg_state   = lcg_next(lcg_state);
  mem[2][7:0] = lcg_state[23:16];
endtask

// File: sim/tb_cpu.sv
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
();

  localparam int mem_words = 2 ** addr_w;

  logic       clk = 1'b0;
  logic       reset;
  word_t      read_data = '0;
  addr_t      mem_addr;
  mem_cmd_e   mem_cmd;
  word_t      write_data;
  logic [2:0] status;
  logic       halted;

  word_t       mem [mem_words];
  logic [31:0] lcg_state = 32'hf8eb124f;
  addr_t       exp_addr [$];   // stores in program order
  word_t       exp_data [$];
  logic [12:0] exp_fetch [$];  // flags valid, n v z, pc
  mem_cmd_e    prev_cmd = mem_none;
  logic        read_seen = 1'b0;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  `include "tb_program.svh"

  cpu u_dut (
    .clk        (clk),
    .reset      (reset),
    .read_data  (read_data),
    .mem_addr   (mem_addr),
    .mem_cmd    (mem_cmd),
    .write_data (write_data),
    .status     (status),
    .halted     (halted)
  );

  always #5 clk = ~clk;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    assert (actual === expected)
      else report_error($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  function automatic word_t shift_one(input word_t v, input logic [1:0] sh);
    case (sh)
      2'b01:   return v << 1;
      2'b10:   return v >> 1;
      2'b11:   return $signed(v) >>> 1;
      default: return v;
    endcase
  endfunction

  // instruction level model, fills the fetch and store tables
  task automatic build_expected();
    word_t      r [reg_cnt];
    word_t      m [mem_words];
    word_t      ir, a, b;
    addr_t      pc, ea;
    logic [2:0] nvz;
    logic       known, take;
    int         d;
    m     = mem;
    r     = '{default: '0};
    pc    = '0;
    nvz   = '0;
    known = 1'b0;
    for (int n = 0; n < mem_words; n++) begin
      exp_fetch.push_back({known, nvz, pc});
      ir = m[pc];
      pc = pc + 1'b1;
      a  = r[ir[10:8]];
      b  = shift_one(r[ir[2:0]], ir[4:3]);
      ea = addr_t'(a + {{11{ir[4]}}, ir[4:0]});  // base + imm5
      case (ir[15:13])
        op_move: begin
          if (ir[12:11] == 2'b10) r[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
          else r[ir[7:5]] = b;
        end
        op_alu: begin
          case (ir[12:11])
            2'b00:   r[ir[7:5]] = a + b;
            2'b10:   r[ir[7:5]] = a & b;
            2'b11:   r[ir[7:5]] = ~b;
            default: begin  // cmp only sets flags
              d     = int'($signed(a)) - int'($signed(b));
              nvz   = {d[15], d > 32767 || d < -32768, d[15:0] == 16'h0};
              known = 1'b1;
            end
          endcase
        end
        op_ldr: r[ir[7:5]] = m[ea];
        op_str: begin
          m[ea] = r[ir[7:5]];  // stored value is never shifted
          exp_addr.push_back(ea);
          exp_data.push_back(r[ir[7:5]]);
        end
        op_branch: begin
          case (branch_cond_e'(ir[10:8]))
            cond_always: take = 1'b1;
            cond_eq:     take = nvz[0];
            cond_ne:     take = !nvz[0];
            cond_lt:     take = nvz[2] ^ nvz[1];
            cond_le:     take = (nvz[2] ^ nvz[1]) | nvz[0];
            default:     take = 1'b0;
          endcase
          if (take) pc = pc + {ir[7], ir[7:0]};  // from the incremented pc
        end
        default: break;  // halt and undefined opcodes
      endcase
    end
  endtask

  // registered reads, writes at the edge that ends the write cycle
  always @(posedge clk) begin : memory_model
    mem_cmd_e cmd;
    addr_t    addr;
    word_t    wdata;
    cmd   = mem_cmd;
    addr  = mem_addr;
    wdata = write_data;
    #1;
    if (cmd == mem_write) mem[addr] = wdata;
    if (cmd == mem_read) read_data = mem[addr];
  end

  // fetches are two read cycles, data reads only one
  always @(posedge clk) begin : fetch_check
    logic [12:0] f;
    if (!reset && mem_cmd == mem_read && !read_seen) begin
      check_value("first read address", 16'h0, 16'(mem_addr));
      read_seen = 1'b1;
    end
    if (!reset && mem_cmd == mem_read && prev_cmd == mem_read) begin
      assert (exp_fetch.size() > 0) else report_error("fetch past the end of the program trace");
      f = exp_fetch.pop_front();
      check_value("fetch address", 16'(f[8:0]), 16'(mem_addr));
      if (f[12]) check_value("status after cmp", 16'(f[11:9]), 16'(status));
    end
    prev_cmd <= mem_cmd;
  end

  always @(posedge clk) begin : store_check
    if (!reset && mem_cmd == mem_write) begin
      assert (mem_addr != poison_addr) else report_error("a skipped store reached memory");
      assert (exp_addr.size() > 0) else report_error("more stores than the program makes");
      check_value("store address", 16'(exp_addr.pop_front()), 16'(mem_addr));
      check_value("store data", exp_data.pop_front(), write_data);
    end
  end

  // bus idle during reset and on the edge where reset is released
  assert property (@(posedge clk) (reset || $fell(reset)) |-> mem_cmd == mem_none && !halted)
    else report_error("bus active or halted high during reset");
  assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else report_error("halted dropped while reset was low");
  assert property (@(posedge clk) disable iff (reset) halted |-> mem_cmd == mem_none)
    else report_error("memory access after halt");

  initial begin : watchdog
    repeat (5 + 40 * prog_len) @(posedge clk);
    report_error("timeout, the core never halted");
  end

  initial begin : main
    reset = 1'b1;
    load_program();
    patch_operands();
    build_expected();
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    wait (halted === 1'b1);
    if (exp_addr.size() != 0 || exp_fetch.size() != 0) begin
      report_error("halted before every expected store and fetch");
    end else begin
      repeat (4) @(posedge clk);  // halt must hold with the bus idle
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`default_nettype none

module cpu
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  word_t       read_data,   // instruction and data words
  output addr_t       mem_addr,
  output mem_cmd_e    mem_cmd,
  output word_t       write_data,
  output logic [2:0]  status,      // n v z
  output logic        halted
);

  dp_ctrl_if u_ctrl_if ();
  instr_if   u_instr_if ();

  logic  pc_load, pc_clear, pc_branch;
  logic  addr_load, addr_from_pc;
  word_t result;

  instr_decoder u_decoder (
    .clk       (clk),
    .read_data (read_data),
    .ctrl      (u_ctrl_if.dec),
    .fields    (u_instr_if.dec)
  );

  control_fsm u_fsm (
    .clk          (clk),
    .reset        (reset),
    .fields       (u_instr_if.fsm),
    .ctrl         (u_ctrl_if.ctrl),
    .pc_load      (pc_load),
    .pc_clear     (pc_clear),
    .pc_branch    (pc_branch),
    .addr_load    (addr_load),
    .addr_from_pc (addr_from_pc),
    .halted       (halted),
    .mem_cmd      (mem_cmd)
  );

  datapath u_datapath (
    .clk       (clk),
    .ctrl      (u_ctrl_if.dp),
    .fields    (u_instr_if.dp),
    .read_data (read_data),
    .result    (result),
    .status    (status)
  );

  pc_unit u_pc (
    .clk          (clk),
    .pc_load      (pc_load),
    .pc_clear     (pc_clear),
    .pc_branch    (pc_branch),
    .addr_load    (addr_load),
    .addr_from_pc (addr_from_pc),
    .status       (status),
    .fields       (u_instr_if.pc),
    .result       (result),
    .mem_addr     (mem_addr)
  );

  assign write_data = result;  // str value sits in c during st_write_mem

endmodule

`default_nettype wire

// File: hw/pc_unit.sv
`default_nettype none

module pc_unit
  import cpu_pkg::*;
(
  input  logic        clk,
  input  logic        pc_load,
  input  logic        pc_clear,
  input  logic        pc_branch,
  input  logic        addr_load,
  input  logic        addr_from_pc,
  input  logic [2:0]  status,
  instr_if.pc         fields,
  input  word_t       result,
  output addr_t       mem_addr
);

  addr_t pc, data_addr;
  logic  n, v, z;
  logic  cond_true;

  assign {n, v, z} = status;

  always_comb begin
    case (fields.cond)
      cond_always: cond_true = 1'b1;
      cond_eq:     cond_true = z;
      cond_ne:     cond_true = !z;
      cond_lt:     cond_true = n ^ v;
      cond_le:     cond_true = (n ^ v) | z;
      default:     cond_true = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (pc_clear) begin
      pc <= '0;
    end else if (pc_load) begin
      pc <= pc + 1'b1;
    end else if (pc_branch && cond_true) begin
      pc <= pc + fields.branch_offset;  // relative to the already incremented pc
    end
  end

  always_ff @(posedge clk) begin
    if (addr_load) begin
      data_addr <= result[addr_w-1:0];  // base + offset from c
    end
  end

  assign mem_addr = addr_from_pc ? pc : data_addr;

  assert property (@(posedge clk) !(pc_load && pc_branch));

endmodule

`default_nettype wire

// File: hw/datapath.sv
`default_nettype none

module datapath
  import cpu_pkg::*;
(
  input  logic        clk,
  dp_ctrl_if.dp       ctrl,
  instr_if.dp         fields,
  input  word_t       read_data,
  output word_t       result,
  output logic [2:0]  status  // n v z
);

  word_t regs [reg_cnt];
  word_t reg_a, reg_b;
  word_t a_in, b_shift, b_in;
  word_t sum, diff, alu_out, wb_data;
  logic  ovf;

  // register file read and write share reg_num
  always_ff @(posedge clk) begin
    if (ctrl.reg_write) begin
      regs[fields.reg_num] <= wb_data;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_a) begin
      reg_a <= regs[fields.reg_num];
    end
    if (ctrl.load_b) begin
      reg_b <= regs[fields.reg_num];
    end
  end

  always_comb begin
    case (fields.shift)
      sh_left:        b_shift = {reg_b[word_w-2:0], 1'b0};
      sh_right_logic: b_shift = {1'b0, reg_b[word_w-1:1]};
      sh_right_arith: b_shift = {reg_b[word_w-1], reg_b[word_w-1:1]};  // keeps sign
      default:        b_shift = reg_b;
    endcase
  end

  assign a_in = ctrl.zero_a ? '0 : reg_a;
  assign b_in = ctrl.imm_b ? fields.sximm5 : b_shift;

  assign sum  = a_in + b_in;
  assign diff = a_in - b_in;
  // signed overflow of a - b
  assign ovf  = (a_in[word_w-1] ^ b_in[word_w-1]) & (diff[word_w-1] ^ a_in[word_w-1]);

  always_comb begin
    case (fields.alu_op)
      alu_add: alu_out = sum;
      alu_sub: alu_out = diff;
      alu_and: alu_out = a_in & b_in;
      default: alu_out = ~b_in;  // mvn
    endcase
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_c) begin
      result <= alu_out;
    end
    if (ctrl.load_status) begin
      status <= {alu_out[word_w-1], ovf, alu_out == '0};
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      wb_imm8:  wb_data = fields.sximm8;
      wb_mdata: wb_data = read_data;  // word from st_read_mem
      default:  wb_data = result;
    endcase
  end

  // memory data only reaches the register file in a write cycle
  assert property (@(posedge clk) ctrl.wb_sel == wb_mdata |-> ctrl.reg_write);

endmodule

`default_nettype wire

// File: hw/control_fsm.sv
`default_nettype none

module control_fsm
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  instr_if.fsm     fields,
  dp_ctrl_if.ctrl  ctrl,
  output logic     pc_load,
  output logic     pc_clear,
  output logic     pc_branch,
  output logic     addr_load,
  output logic     addr_from_pc,
  output logic     halted,
  output mem_cmd_e mem_cmd
);

  state_e state, state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_reset;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_reset:     state_next = st_if1;
      st_if1:       state_next = st_if2;
      st_if2:       state_next = st_update_pc;  // ir loads at the end of this cycle
      st_update_pc: begin
        case (fields.opcode)
          op_move:        state_next = (fields.op == 2'b10) ? st_write_imm : st_get_b;
          op_alu:         state_next = (alu_op_e'(fields.op) == alu_not) ? st_get_b : st_get_a;
          op_ldr, op_str: state_next = st_get_a;  // base register first
          op_branch:      state_next = st_branch;
          default:        state_next = st_halt;  // halt and undefined opcodes stop the core
        endcase
      end
      st_get_a:     state_next = (fields.opcode == op_move || fields.opcode == op_alu) ?
                                 st_get_b : st_add_imm5;
      st_get_b: begin
        if (fields.opcode == op_move) begin
          state_next = st_pass;
        end else if (alu_op_e'(fields.op) == alu_sub) begin
          state_next = st_compare;  // cmp only updates the flags
        end else begin
          state_next = st_operate;
        end
      end
      st_pass, st_operate: state_next = st_write_reg;
      st_add_imm5:         state_next = st_load_addr;
      st_load_addr:        state_next = (fields.opcode == op_ldr) ? st_read_mem : st_get_rd;
      st_read_mem:         state_next = st_mem_to_reg;
      st_get_rd:           state_next = st_pass_rd;
      st_pass_rd:          state_next = st_write_mem;
      st_compare, st_write_reg, st_write_imm, st_mem_to_reg, st_write_mem, st_branch:
                           state_next = st_if1;
      st_halt:             state_next = st_halt;  // left only through reset
      default:             state_next = st_reset;
    endcase
  end

  always_comb begin
    ctrl.load_a      = 1'b0;
    ctrl.load_b      = 1'b0;
    ctrl.zero_a      = 1'b0;
    ctrl.imm_b       = 1'b0;
    ctrl.load_c      = 1'b0;
    ctrl.load_status = 1'b0;
    ctrl.reg_write   = 1'b0;
    ctrl.wb_sel      = wb_result;
    ctrl.reg_sel     = sel_rm;
    ctrl.load_ir     = 1'b0;
    pc_load          = 1'b0;
    pc_clear         = 1'b0;
    pc_branch        = 1'b0;
    addr_load        = 1'b0;
    addr_from_pc     = 1'b0;
    halted           = 1'b0;
    mem_cmd          = mem_none;
    case (state)
      st_reset:     pc_clear = 1'b1;
      st_if1: begin
        addr_from_pc = 1'b1;
        mem_cmd      = mem_read;
      end
      st_if2: begin
        addr_from_pc = 1'b1;
        mem_cmd      = mem_read;  // held so the word stays valid
        ctrl.load_ir = 1'b1;
      end
      st_update_pc: pc_load = 1'b1;  // pc + 1
      st_get_a: begin
        ctrl.reg_sel = sel_rn;
        ctrl.load_a  = 1'b1;
      end
      st_get_b:     ctrl.load_b = 1'b1;  // rm
      st_pass, st_pass_rd: begin
        ctrl.zero_a = 1'b1;  // 0 + b through the adder
        ctrl.load_c = 1'b1;
      end
      st_compare:   ctrl.load_status = 1'b1;
      st_operate:   ctrl.load_c = 1'b1;
      st_write_reg: begin
        ctrl.reg_sel   = sel_rd;
        ctrl.reg_write = 1'b1;
      end
      st_write_imm: begin
        ctrl.reg_sel   = sel_rn;
        ctrl.wb_sel    = wb_imm8;
        ctrl.reg_write = 1'b1;
      end
      st_add_imm5: begin
        ctrl.imm_b  = 1'b1;  // base + sximm5
        ctrl.load_c = 1'b1;
      end
      st_load_addr: addr_load = 1'b1;
      st_read_mem:  mem_cmd = mem_read;  // data comes back next cycle
      st_mem_to_reg: begin
        ctrl.reg_sel   = sel_rd;
        ctrl.wb_sel    = wb_mdata;
        ctrl.reg_write = 1'b1;
      end
      st_get_rd: begin
        ctrl.reg_sel = sel_rd;
        ctrl.load_b  = 1'b1;  // store value
      end
      st_write_mem: mem_cmd = mem_write;  // write_data is c
      st_branch:    pc_branch = 1'b1;
      st_halt:      halted = 1'b1;
      default:      pc_clear = 1'b0;
    endcase
  end

  // a register write and a memory write never share a cycle
  assert property (@(posedge clk) disable iff (reset)
    !(ctrl.reg_write && mem_cmd == mem_write));

  assert property (@(posedge clk) disable iff (reset) halted |=> halted);

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`default_nettype none

module instr_decoder
  import cpu_pkg::*;
(
  input  logic          clk,
  input  word_t         read_data,
  dp_ctrl_if.dec        ctrl,
  instr_if.dec          fields
);

  word_t ir;  // current instruction

  always_ff @(posedge clk) begin
    if (ctrl.load_ir) begin
      ir <= read_data;  // memory word is valid in st_if2
    end
  end

  // layout: opcode[15:13] op[12:11] rn[10:8] rd[7:5] shift[4:3] rm[2:0]
  assign fields.opcode        = opcode_e'(ir[15:13]);
  assign fields.op            = ir[12:11];
  assign fields.alu_op        = alu_op_e'(ir[12:11]);
  assign fields.cond          = branch_cond_e'(ir[10:8]);  // branches reuse the rn slot
  assign fields.sximm5        = {{11{ir[4]}}, ir[4:0]};
  assign fields.sximm8        = {{8{ir[7]}}, ir[7:0]};
  assign fields.branch_offset = {ir[7], ir[7:0]};  // 9 bit signed step

  always_comb begin
    case (ctrl.reg_sel)
      sel_rn:  fields.reg_num = ir[10:8];
      sel_rd:  fields.reg_num = ir[7:5];
      default: fields.reg_num = ir[2:0];  // sel_rm
    endcase
  end

  // bits 4:3 are part of imm5 on ldr/str so the store value must pass unshifted
  always_comb begin
    if (fields.opcode == op_move || fields.opcode == op_alu) begin
      fields.shift = shift_e'(ir[4:3]);
    end else begin
      fields.shift = sh_none;
    end
  end

endmodule

`default_nettype wire

// File: hw/instr_if.sv
`default_nettype none

interface instr_if
  import cpu_pkg::*;
();
  opcode_e              opcode;
  logic [1:0]           op;
  logic [reg_idx_w-1:0] reg_num;        // rn, rd or rm per reg_sel
  alu_op_e              alu_op;
  shift_e               shift;
  word_t                sximm5;         // memory offset
  word_t                sximm8;         // move immediate
  branch_cond_e         cond;
  addr_t                branch_offset;  // pc relative jump

  modport dec (output opcode, op, reg_num, alu_op, shift, sximm5, sximm8, cond,
               branch_offset);
  modport fsm (input opcode, op);
  modport dp  (input reg_num, alu_op, shift, sximm5, sximm8);
  modport pc  (input cond, branch_offset);
endinterface

`default_nettype wire

// File: hw/dp_ctrl_if.sv
`default_nettype none

interface dp_ctrl_if
  import cpu_pkg::*;
();
  logic     load_a;       // latch register file output into a
  logic     load_b;       // latch register file output into b
  logic     zero_a;       // a operand forced to 0
  logic     imm_b;        // b operand taken from sximm5
  logic     load_c;       // latch alu result
  logic     load_status;  // latch n v z
  logic     reg_write;
  wb_sel_e  wb_sel;
  reg_sel_e reg_sel;
  logic     load_ir;

  modport ctrl (output load_a, load_b, zero_a, imm_b, load_c, load_status, reg_write,
                wb_sel, reg_sel, load_ir);
  modport dp   (input load_a, load_b, zero_a, imm_b, load_c, load_status, reg_write, wb_sel);
  modport dec  (input reg_sel, load_ir);
endinterface

`default_nettype wire

// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  localparam int word_w    = 16;  // data word
  localparam int addr_w    = 9;   // 512 word memory
  localparam int reg_cnt   = 8;   // general registers r0..r7
  localparam int reg_idx_w = 3;

  typedef logic [word_w-1:0] word_t;
  typedef logic [addr_w-1:0] addr_t;

  typedef enum logic [2:0] {
    op_branch = 3'b001,
    op_ldr    = 3'b011,
    op_str    = 3'b100,
    op_alu    = 3'b101,
    op_move   = 3'b110,
    op_halt   = 3'b111
  } opcode_e;

  // op field of alu instructions
  typedef enum logic [1:0] {alu_add, alu_sub, alu_and, alu_not} alu_op_e;

  // single bit shift applied to operand b
  typedef enum logic [1:0] {sh_none, sh_left, sh_right_logic, sh_right_arith} shift_e;

  typedef enum logic [2:0] {cond_always, cond_eq, cond_ne, cond_lt, cond_le} branch_cond_e;

  typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_cmd_e;

  typedef enum logic [1:0] {sel_rn, sel_rd, sel_rm} reg_sel_e;  // register file index source

  typedef enum logic [1:0] {wb_result, wb_imm8, wb_mdata} wb_sel_e;  // write-back source

  typedef enum logic [4:0] {
    st_reset, st_if1, st_if2, st_update_pc,
    st_get_a, st_get_b, st_pass, st_compare, st_operate, st_write_reg, st_write_imm,
    st_add_imm5, st_load_addr, st_read_mem, st_mem_to_reg, st_get_rd, st_pass_rd,
    st_write_mem,
    st_branch, st_halt
  } state_e;

endpackage

`default_nettype wire
